// File: Bender.yml
package:
  name: parser_top

sources:
  - common/parser_pkg.sv
  - rtl/header_capture.sv
  - action_table/table_write_ctrl.sv
  - action_table/parse_action_table.sv
  - field_extract/sub_parser.sv
  - field_extract/field_extract.sv
  - rtl/container_bank.sv
  - rtl/parser_top.sv
  - target: test
    files:
      - tb/parser_checker.sv
      - tb/tb_parser_top.sv

// File: action_table/parse_action_table.sv
module parse_action_table (
	input  logic                          axis_clk,
	input  logic                          aresetn,
	input  logic                          wr_en,
	input  logic [parser_pkg::ADDR_W-1:0] wr_addr,
	input  parser_pkg::action_entry_t     wr_entry,
	input  parser_pkg::hdr_t              hdr,
	input  logic                          hdr_valid,
	output parser_pkg::action_entry_t     actions,
	output parser_pkg::hdr_t              hdr_q,
	output logic                          act_valid
);

	parser_pkg::action_entry_t mem [parser_pkg::TABLE_DEPTH];
	logic [parser_pkg::ADDR_W-1:0] rd_addr;

	// upper nibble of the low VLAN ID byte picks the entry
	assign rd_addr = hdr.field[parser_pkg::VLAN_LSB+4 +: parser_pkg::ADDR_W];

	// every entry reads zero after reset
	always_ff @(posedge axis_clk) begin
		if (!aresetn) begin
			for (int i = 0; i < parser_pkg::TABLE_DEPTH; i++)
				mem[i] <= '0;
		end else if (wr_en) begin
			mem[wr_addr] <= wr_entry;
		end
	end

	// lookup stage moves the entry and the header on together
	always_ff @(posedge axis_clk) begin
		actions <= mem[rd_addr];
		hdr_q <= hdr;
	end

	always_ff @(posedge axis_clk) begin
		if (!aresetn)
			act_valid <= 1'b0;
		else
			act_valid <= hdr_valid;
	end

endmodule

// File: action_table/table_write_ctrl.sv
module table_write_ctrl #(
	parameter logic [2:0] PARSER_MOD_ID = 3'd0
) (
	input  logic                          axis_clk,
	input  logic                          aresetn,
	input  logic [parser_pkg::SEG_W-1:0]  ctrl_tdata,
	input  logic                          ctrl_tvalid,
	input  logic                          ctrl_tlast,
	output logic                          wr_en,
	output logic [parser_pkg::ADDR_W-1:0] wr_addr,
	output parser_pkg::action_entry_t     wr_entry
);

	typedef enum logic [1:0] {
		C_FIRST,
		C_SECOND,
		C_ENTRY,
		C_FLUSH
	} ctrl_state_e;

	ctrl_state_e state;
	logic id_match;
	parser_pkg::action_entry_t entry_swapped;

	assign id_match = (ctrl_tdata[parser_pkg::CTRL_ID_LSB +: 3] == PARSER_MOD_ID);

	// action i sits in bytes 2i and 2i+1, lower byte is the high half
	always_comb begin
		for (int i = 0; i < parser_pkg::NUM_ACTIONS; i++)
			entry_swapped[i] = {ctrl_tdata[16*i +: 8], ctrl_tdata[16*i+8 +: 8]};
	end

	always_ff @(posedge axis_clk) begin
		if (!aresetn) begin
			state <= C_FIRST;
			wr_en <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			if (ctrl_tvalid) begin
				case (state)
					C_FIRST: state <= ctrl_tlast ? C_FIRST : C_SECOND;
					C_SECOND: begin
						if (ctrl_tlast)
							state <= C_FIRST;
						else
							state <= id_match ? C_ENTRY : C_FLUSH;
					end
					C_ENTRY: begin
						// entry is written even when the packet runs on
						wr_en <= 1'b1;
						state <= ctrl_tlast ? C_FIRST : C_FLUSH;
					end
					C_FLUSH: begin
						if (ctrl_tlast)
							state <= C_FIRST;
					end
					default: state <= C_FIRST;
				endcase
			end
		end
	end

	always_ff @(posedge axis_clk) begin
		if (ctrl_tvalid && state == C_SECOND)
			wr_addr <= ctrl_tdata[parser_pkg::CTRL_ADDR_LSB +: parser_pkg::ADDR_W];
		if (ctrl_tvalid && state == C_ENTRY)
			wr_entry <= entry_swapped;
	end

endmodule

// File: common/parser_pkg.sv
package parser_pkg;

	// stream and header geometry
	localparam int SEG_W = 256;
	localparam int TUSER_W = 128;
	localparam int MAX_SEGS = 4;
	localparam int HDR_W = MAX_SEGS * SEG_W;
	localparam int HDR_BYTES = HDR_W / 8;

	// action table
	localparam int NUM_ACTIONS = 10;
	localparam int NUM_CONT = 8;
	localparam int TABLE_DEPTH = 16;
	localparam int ADDR_W = $clog2(TABLE_DEPTH);

	// field positions
	localparam int VLAN_LSB = 116;
	localparam int VLAN_W = 12;
	localparam int CTRL_ID_LSB = 112;
	localparam int CTRL_ADDR_LSB = 128;

	typedef enum logic [1:0] {
		CT_NONE = 2'd0,
		CT_2B = 2'd1,
		CT_4B = 2'd2,
		CT_6B = 2'd3
	} cont_type_e;

	typedef struct packed {
		logic [2:0] reserved;
		logic [6:0] byte_offset;
		cont_type_e ctype;
		logic [2:0] seq;
		logic valid;
	} action_t;

	typedef action_t [NUM_ACTIONS-1:0] action_entry_t;

	typedef struct packed {
		cont_type_e ctype;
		logic [2:0] seq;
		logic [47:0] value;
	} extract_t;

	typedef struct packed {
		logic [HDR_W-1:0] field;
		logic [TUSER_W-1:0] tuser;
	} hdr_t;

	// 8*48 + 8*32 + 8*16 + 12 + 128 = 908 bits
	typedef struct packed {
		logic [NUM_CONT-1:0][47:0] cont_6b;
		logic [NUM_CONT-1:0][31:0] cont_4b;
		logic [NUM_CONT-1:0][15:0] cont_2b;
		logic [VLAN_W-1:0] vlan_id;
		logic [TUSER_W-1:0] tuser;
	} phv_t;

endpackage

// File: field_extract/field_extract.sv
module field_extract (
	input  logic                                             axis_clk,
	input  logic                                             aresetn,
	input  parser_pkg::action_entry_t                        actions,
	input  parser_pkg::hdr_t                                 hdr_q,
	input  logic                                             act_valid,
	output parser_pkg::extract_t [parser_pkg::NUM_ACTIONS-1:0] ext,
	output logic [parser_pkg::TUSER_W-1:0]                   tuser_q,
	output logic [parser_pkg::VLAN_W-1:0]                    vlan_q,
	output logic                                             ext_valid
);

	// all ten actions run in parallel on the same header
	for (genvar i = 0; i < parser_pkg::NUM_ACTIONS; i++) begin : g_sub
		sub_parser u_sub (
			.axis_clk  (axis_clk),
			.aresetn   (aresetn),
			.action    (actions[i]),
			.hdr_field (hdr_q.field),
			.ext       (ext[i])
		);
	end

	// metadata follows the sub-parser latency
	always_ff @(posedge axis_clk) begin
		tuser_q <= hdr_q.tuser;
		vlan_q <= hdr_q.field[parser_pkg::VLAN_LSB +: parser_pkg::VLAN_W];
	end

	always_ff @(posedge axis_clk) begin
		if (!aresetn)
			ext_valid <= 1'b0;
		else
			ext_valid <= act_valid;
	end

endmodule

// File: field_extract/sub_parser.sv
module sub_parser (
	input  logic                         axis_clk,
	input  logic                         aresetn,
	input  parser_pkg::action_t          action,
	input  logic [parser_pkg::HDR_W-1:0] hdr_field,
	output parser_pkg::extract_t         ext
);

	logic [2:0] nbytes;
	parser_pkg::extract_t ext_d;

	// reads past the captured header come back as zero
	function automatic logic [7:0] hdr_byte(input logic [parser_pkg::HDR_W-1:0] field,
			input logic [7:0] idx);
		if (idx < parser_pkg::HDR_BYTES)
			return field[idx*8 +: 8];
		return 8'h00;
	endfunction

	always_comb begin
		case (action.ctype)
			parser_pkg::CT_2B: nbytes = 3'd2;
			parser_pkg::CT_4B: nbytes = 3'd4;
			parser_pkg::CT_6B: nbytes = 3'd6;
			default: nbytes = 3'd0;
		endcase
		ext_d.seq = action.seq;
		ext_d.ctype = (action.valid && nbytes != 3'd0) ? action.ctype : parser_pkg::CT_NONE;
		// first byte ends up most significant
		ext_d.value = '0;
		for (int j = 0; j < 6; j++) begin
			if (j < nbytes)
				ext_d.value = {ext_d.value[39:0], hdr_byte(hdr_field, 8'(action.byte_offset + j))};
		end
	end

	always_ff @(posedge axis_clk) begin
		if (!aresetn)
			ext <= '0;
		else
			ext <= ext_d;
	end

endmodule

// File: parser_top.f
common/parser_pkg.sv
rtl/header_capture.sv
action_table/table_write_ctrl.sv
action_table/parse_action_table.sv
field_extract/sub_parser.sv
field_extract/field_extract.sv
rtl/container_bank.sv
rtl/parser_top.sv
tb/parser_checker.sv
tb/tb_parser_top.sv

// File: rtl/container_bank.sv
module container_bank (
	input  logic                                               axis_clk,
	input  logic                                               aresetn,
	input  parser_pkg::extract_t [parser_pkg::NUM_ACTIONS-1:0] ext,
	input  logic [parser_pkg::TUSER_W-1:0]                     tuser_q,
	input  logic [parser_pkg::VLAN_W-1:0]                      vlan_q,
	input  logic                                               ext_valid,
	input  logic                                               next_stage_ready,
	output parser_pkg::phv_t                                   phv,
	output logic                                               phv_valid,
	output logic                                               phv_done
);

	parser_pkg::phv_t phv_q;
	parser_pkg::phv_t phv_merged;
	logic pending;

	assign phv = phv_q;
	assign phv_valid = pending && next_stage_ready;
	// same pulse releases the capture FSM
	assign phv_done = phv_valid;

	// later actions overwrite earlier ones on a shared container
	always_comb begin
		phv_merged = phv_q;
		phv_merged.vlan_id = vlan_q;
		phv_merged.tuser = tuser_q;
		for (int i = 0; i < parser_pkg::NUM_ACTIONS; i++) begin
			case (ext[i].ctype)
				parser_pkg::CT_2B: phv_merged.cont_2b[ext[i].seq] = ext[i].value[15:0];
				parser_pkg::CT_4B: phv_merged.cont_4b[ext[i].seq] = ext[i].value[31:0];
				parser_pkg::CT_6B: phv_merged.cont_6b[ext[i].seq] = ext[i].value;
				default: ;
			endcase
		end
	end

	always_ff @(posedge axis_clk) begin
		if (!aresetn) begin
			phv_q <= '0;
			pending <= 1'b0;
		end else if (ext_valid) begin
			phv_q <= phv_merged;
			pending <= 1'b1;
		end else if (phv_valid) begin
			// empty containers for the next packet
			phv_q.cont_6b <= '0;
			phv_q.cont_4b <= '0;
			phv_q.cont_2b <= '0;
			pending <= 1'b0;
		end
	end

endmodule

// File: rtl/header_capture.sv
module header_capture (
	input  logic                           axis_clk,
	input  logic                           aresetn,
	input  logic [parser_pkg::SEG_W-1:0]   s_axis_tdata,
	input  logic [parser_pkg::TUSER_W-1:0] s_axis_tuser,
	input  logic                           s_axis_tvalid,
	input  logic                           s_axis_tlast,
	output logic                           s_axis_tready,
	input  logic                           phv_done,
	output parser_pkg::hdr_t               hdr,
	output logic                           hdr_valid
);

	// low two bits of the segment states give the segment index
	typedef enum logic [2:0] {
		S_SEG1 = 3'd0,
		S_SEG2 = 3'd1,
		S_SEG3 = 3'd2,
		S_SEG4 = 3'd3,
		S_DISCARD = 3'd4,
		S_WAIT_DONE = 3'd5
	} state_e;

	state_e state;
	logic beat;
	logic [1:0] seg_idx;

	// one packet in flight, so hold off until its PHV has left
	assign s_axis_tready = (state != S_WAIT_DONE);
	assign beat = s_axis_tvalid && s_axis_tready;
	assign seg_idx = state[1:0];

	always_ff @(posedge axis_clk) begin
		if (!aresetn) begin
			state <= S_SEG1;
			hdr_valid <= 1'b0;
		end else begin
			hdr_valid <= 1'b0;
			case (state)
				S_SEG1, S_SEG2, S_SEG3, S_SEG4: begin
					if (beat) begin
						if (s_axis_tlast) begin
							state <= S_WAIT_DONE;
							hdr_valid <= 1'b1;
						end else if (state == S_SEG4) begin
							state <= S_DISCARD;
						end else begin
							state <= state_e'(state + 3'd1);
						end
					end
				end
				S_DISCARD: begin
					if (beat && s_axis_tlast) begin
						state <= S_WAIT_DONE;
						hdr_valid <= 1'b1;
					end
				end
				S_WAIT_DONE: begin
					if (phv_done)
						state <= S_SEG1;
				end
				default: state <= S_SEG1;
			endcase
		end
	end

	// segments not received stay zero
	always_ff @(posedge axis_clk) begin
		if (beat) begin
			if (state == S_SEG1) begin
				hdr.field <= {{(parser_pkg::HDR_W-parser_pkg::SEG_W){1'b0}}, s_axis_tdata};
				hdr.tuser <= s_axis_tuser;
			end else if (state != S_DISCARD) begin
				hdr.field[seg_idx*parser_pkg::SEG_W +: parser_pkg::SEG_W] <= s_axis_tdata;
			end
		end
	end

endmodule

// File: rtl/parser_top.sv
module parser_top #(
	parameter logic [2:0] PARSER_MOD_ID = 3'd0
) (
	input  logic                               axis_clk,
	input  logic                               aresetn,
	input  logic [parser_pkg::SEG_W-1:0]       s_axis_tdata,
	input  logic [parser_pkg::TUSER_W-1:0]     s_axis_tuser,
	input  logic                               s_axis_tvalid,
	input  logic                               s_axis_tlast,
	output logic                               s_axis_tready,
	input  logic [parser_pkg::SEG_W-1:0]       ctrl_tdata,
	input  logic                               ctrl_tvalid,
	input  logic                               ctrl_tlast,
	input  logic                               next_stage_ready,
	output parser_pkg::phv_t                   phv,
	output logic                               phv_valid
);

	// capture -> lookup
	parser_pkg::hdr_t hdr;
	logic hdr_valid;

	// lookup -> extract
	parser_pkg::action_entry_t actions;
	parser_pkg::hdr_t hdr_q;
	logic act_valid;

	// extract -> containers
	parser_pkg::extract_t [parser_pkg::NUM_ACTIONS-1:0] ext;
	logic [parser_pkg::TUSER_W-1:0] tuser_q;
	logic [parser_pkg::VLAN_W-1:0] vlan_q;
	logic ext_valid;
	logic phv_done;

	// control path into the table
	logic wr_en;
	logic [parser_pkg::ADDR_W-1:0] wr_addr;
	parser_pkg::action_entry_t wr_entry;

	header_capture u_capture (
		.axis_clk      (axis_clk),
		.aresetn       (aresetn),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tuser  (s_axis_tuser),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tlast  (s_axis_tlast),
		.s_axis_tready (s_axis_tready),
		.phv_done      (phv_done),
		.hdr           (hdr),
		.hdr_valid     (hdr_valid)
	);

	table_write_ctrl #(
		.PARSER_MOD_ID (PARSER_MOD_ID)
	) u_table_wr (
		.axis_clk    (axis_clk),
		.aresetn     (aresetn),
		.ctrl_tdata  (ctrl_tdata),
		.ctrl_tvalid (ctrl_tvalid),
		.ctrl_tlast  (ctrl_tlast),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_entry    (wr_entry)
	);

	parse_action_table u_table (
		.axis_clk  (axis_clk),
		.aresetn   (aresetn),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_entry  (wr_entry),
		.hdr       (hdr),
		.hdr_valid (hdr_valid),
		.actions   (actions),
		.hdr_q     (hdr_q),
		.act_valid (act_valid)
	);

	field_extract u_extract (
		.axis_clk  (axis_clk),
		.aresetn   (aresetn),
		.actions   (actions),
		.hdr_q     (hdr_q),
		.act_valid (act_valid),
		.ext       (ext),
		.tuser_q   (tuser_q),
		.vlan_q    (vlan_q),
		.ext_valid (ext_valid)
	);

	container_bank u_bank (
		.axis_clk         (axis_clk),
		.aresetn          (aresetn),
		.ext              (ext),
		.tuser_q          (tuser_q),
		.vlan_q           (vlan_q),
		.ext_valid        (ext_valid),
		.next_stage_ready (next_stage_ready),
		.phv              (phv),
		.phv_valid        (phv_valid),
		.phv_done         (phv_done)
	);

endmodule

// File: tb/parser_checker.sv
module parser_checker (
	input logic             axis_clk,
	input logic             aresetn,
	input logic             s_axis_tvalid,
	input logic             s_axis_tlast,
	input logic             s_axis_tready,
	input logic             next_stage_ready,
	input parser_pkg::phv_t phv,
	input logic             phv_valid
);

	parser_pkg::phv_t exp_q[$];
	parser_pkg::phv_t exp;
	int errors = 0;
	int errors_at_start = 0;
	int tests_run = 0;
	int tests_failed = 0;
	logic in_flight;
	logic valid_d;
	int age;

	function automatic int outstanding();
		return exp_q.size();
	endfunction

	task automatic expect_phv(input parser_pkg::phv_t e);
		exp_q.push_back(e);
	endtask

	task automatic compare_field(input logic [8*12-1:0] name, input int idx,
			input logic [127:0] expv, input logic [127:0] gotv);
		if (expv !== gotv) begin
			errors++;
			if (idx < 0)
				$display("Mismatch at %0t: %0s expected %0h, got %0h", $time, name, expv, gotv);
			else
				$display("Mismatch at %0t: %0s[%0d] expected %0h, got %0h",
					$time, name, idx, expv, gotv);
		end
	endtask

	task automatic finish_test(input logic [8*24-1:0] name);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("test %0s: ok", name);
		end else begin
			tests_failed++;
			$display("test %0s: %0d errors", name, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	task automatic report_counts();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
	endtask

	always @(posedge axis_clk) begin
		if (!aresetn) begin
			in_flight <= 1'b0;
			valid_d <= 1'b0;
			age <= 0;
		end else begin
			valid_d <= phv_valid;
			// no new packet may enter while one is in the pipeline
			if (in_flight && s_axis_tready) begin
				errors++;
				$display("Mismatch at %0t: s_axis_tready expected 0, got 1", $time);
			end
			// PHV is due in the first ready cycle from three edges after the last beat
			if (in_flight)
				age <= age + 1;
			if (in_flight && age >= 3 && next_stage_ready && !phv_valid) begin
				errors++;
				$display("phv_valid missing at %0t although next_stage_ready was high",
					$time);
			end
			if (phv_valid) begin
				if (in_flight && age < 3) begin
					errors++;
					$display("phv_valid at %0t came too soon after the last beat", $time);
				end
				if (!next_stage_ready) begin
					errors++;
					$display("phv_valid was high at %0t while next_stage_ready was low", $time);
				end
				if (valid_d) begin
					errors++;
					$display("phv_valid stayed high for more than one cycle at %0t", $time);
				end
				if (exp_q.size() == 0) begin
					errors++;
					$display("phv_valid at %0t with no packet outstanding", $time);
				end else begin
					exp = exp_q.pop_front();
					compare_field("phv.vlan_id", -1, 128'(exp.vlan_id), 128'(phv.vlan_id));
					compare_field("phv.tuser", -1, exp.tuser, phv.tuser);
					for (int i = 0; i < parser_pkg::NUM_CONT; i++) begin
						compare_field("phv.cont_6b", i, 128'(exp.cont_6b[i]), 128'(phv.cont_6b[i]));
						compare_field("phv.cont_4b", i, 128'(exp.cont_4b[i]), 128'(phv.cont_4b[i]));
						compare_field("phv.cont_2b", i, 128'(exp.cont_2b[i]), 128'(phv.cont_2b[i]));
					end
				end
				in_flight <= 1'b0;
			end else if (s_axis_tvalid && s_axis_tready && s_axis_tlast) begin
				in_flight <= 1'b1;
				age <= 0;
			end
		end
	end

endmodule

// File: tb/parser_golden.txt
# T name | R ready mode (1 high, 2 random) | C tlast tdata | P tlast tuser tdata
# K width index value, V vlan_id tuser: expected PHV of the next packet | E end of test
T extraction
R 1
C 0 0
C 0 0300020000000000000000000000000000
C 1 3f1f3b009f1f151823103108
K 6 0 a1a2a3a4a5a6
K 4 1 c1c2c3c4
K 2 2 d1d2
K 2 7 f3f4
K 6 5 000102030405
K 6 7 f1f2f3f40000
V 432 1234abcd
P 0 1234abcd 43210d0c0b0a09080706050403020100
P 0 ff b7b6a6a5a4a3a2a1
P 0 ff c4c3c2c1
P 1 ff f4f3f2f10000000000000000000000000000000000000000000000000000d2d1
E
T entry_select
C 0 0
C 0 0900020000000000000000000000000000
C 1 ad001100
K 2 0 1122
K 4 6 33445566
V 59b 2
P 1 2 59b00000000000000077665544332211
K 6 5 112233445566
V 337 3
P 1 3 33700000000000000077665544332211
E
T id_filter
C 0 0
C 0 0900050000000000000000000000000000
C 1 ffffffff
K 2 0 1122
K 4 6 33445566
V 59b 4
P 1 4 59b00000000000000077665544332211
E
T pkt_length
K 6 5 000102030405
V 432 5
P 1 5 43210d0c0b0a09080706050403020100
K 6 0 a1a2a3a4a5a6
K 6 5 000102030405
V 432 6
P 0 6 43210d0c0b0a09080706050403020100
P 1 ff b7b6a6a5a4a3a2a1
K 6 0 a1a2a3a4a5a6
K 4 1 c1c2c3c4
K 2 2 d1d2
K 2 7 f3f4
K 6 5 000102030405
K 6 7 f1f2f3f40000
V 432 7
P 0 7 43210d0c0b0a09080706050403020100
P 0 ff b7b6a6a5a4a3a2a1
P 0 ff c4c3c2c1
P 0 ff f4f3f2f10000000000000000000000000000000000000000000000000000d2d1
P 0 ff eeeeeeee
P 1 ff dddddddd
E
T backpressure
R 2
K 2 0 1122
K 4 6 33445566
V 59b 8
P 1 8 59b00000000000000077665544332211
K 2 0 1122
K 4 6 33445566
V 59b 9
P 1 9 59b00000000000000077665544332211
K 2 0 1122
K 4 6 33445566
V 59b a
P 1 a 59b00000000000000077665544332211
R 1
E
T collision
C 0 0
C 0 0c00020000000000000000000000000000
C 1 93001300
K 2 1 3344
V 5c0 b
P 1 b 5c000000000000000077665544332211
E

// File: tb/tb_parser_top.sv
module tb_parser_top;

	// one golden file record with fields used according to tag
	typedef struct packed {
		logic [7:0] tag;
		logic [31:0] a;
		logic [31:0] b;
		logic [127:0] u;
		logic [255:0] d;
	} golden_rec_t;

	logic axis_clk;
	logic aresetn;
	logic [parser_pkg::SEG_W-1:0] s_axis_tdata;
	logic [parser_pkg::TUSER_W-1:0] s_axis_tuser;
	logic s_axis_tvalid;
	logic s_axis_tlast;
	logic s_axis_tready;
	logic [parser_pkg::SEG_W-1:0] ctrl_tdata;
	logic ctrl_tvalid;
	logic ctrl_tlast;
	logic next_stage_ready;
	parser_pkg::phv_t phv;
	logic phv_valid;

	golden_rec_t recs[$];
	logic [8*24-1:0] names[$];
	golden_rec_t rec;
	parser_pkg::phv_t exp_phv;
	logic [8*24-1:0] cur_name;
	int ready_mode = 1;
	int file_errors = 0;
	int limit = 0;
	int cycles = 0;
	integer seed = 32'h97c6_587a;
	integer rnd;

	parser_top #(
		.PARSER_MOD_ID (3'd2)
	) DUT (
		.axis_clk         (axis_clk),
		.aresetn          (aresetn),
		.s_axis_tdata     (s_axis_tdata),
		.s_axis_tuser     (s_axis_tuser),
		.s_axis_tvalid    (s_axis_tvalid),
		.s_axis_tlast     (s_axis_tlast),
		.s_axis_tready    (s_axis_tready),
		.ctrl_tdata       (ctrl_tdata),
		.ctrl_tvalid      (ctrl_tvalid),
		.ctrl_tlast       (ctrl_tlast),
		.next_stage_ready (next_stage_ready),
		.phv              (phv),
		.phv_valid        (phv_valid)
	);

	parser_checker u_checker (
		.axis_clk         (axis_clk),
		.aresetn          (aresetn),
		.s_axis_tvalid    (s_axis_tvalid),
		.s_axis_tlast     (s_axis_tlast),
		.s_axis_tready    (s_axis_tready),
		.next_stage_ready (next_stage_ready),
		.phv              (phv),
		.phv_valid        (phv_valid)
	);

	initial begin
		axis_clk = 1'b0;
		forever #10 axis_clk = ~axis_clk;
	end

	// ready level changes shortly after each edge
	initial begin
		next_stage_ready = 1'b1;
		forever begin
			@(posedge axis_clk);
			#2;
			if (ready_mode == 2) begin
				rnd = $random(seed);
				next_stage_ready = rnd[0];
			end else begin
				next_stage_ready = 1'b1;
			end
		end
	end

	initial begin
		while (limit == 0 || cycles < limit) begin
			@(posedge axis_clk);
			cycles++;
		end
		$display("timeout: run stopped after %0d cycles, %0d PHVs still expected",
			cycles, u_checker.outstanding());
		$display("*** TEST FAILED ***");
		$finish;
	end

	function automatic int fields_in_record(input logic [7:0] tag);
		case (tag)
			"T", "R": return 1;
			"C", "V": return 2;
			"P", "K": return 3;
			default: return 0;
		endcase
	endfunction

	task automatic load_golden();
		integer fd;
		integer code;
		integer a;
		integer b;
		logic [7:0] tag;
		logic [127:0] u;
		logic [255:0] d;
		logic [8*120-1:0] line;
		logic [8*24-1:0] nm;
		golden_rec_t r;
		fd = $fopen("tb/parser_golden.txt", "r");
		if (fd == 0) begin
			file_errors++;
			$display("cannot open tb/parser_golden.txt");
		end else begin
			while ($fscanf(fd, " %c", tag) == 1) begin
				a = 0;
				b = 0;
				u = '0;
				d = '0;
				code = 0;
				case (tag)
					"#": code = $fgets(line, fd);
					"T": begin
						code = $fscanf(fd, "%s", nm);
						a = names.size();
						names.push_back(nm);
					end
					"R": code = $fscanf(fd, "%d", a);
					"C": code = $fscanf(fd, "%d %h", a, d);
					"P": code = $fscanf(fd, "%d %h %h", a, u, d);
					"K": code = $fscanf(fd, "%d %d %h", a, b, u);
					"V": code = $fscanf(fd, "%h %h", a, u);
					"E": code = 0;
					default: begin
						file_errors++;
						$display("golden file has an unknown record tag '%c'", tag);
					end
				endcase
				if (tag != "#" && code != fields_in_record(tag)) begin
					file_errors++;
					$display("golden file record '%c' has missing or unreadable fields", tag);
				end
				r.tag = tag;
				r.a = a;
				r.b = b;
				r.u = u;
				r.d = d;
				if (tag != "#")
					recs.push_back(r);
			end
			$fclose(fd);
		end
	endtask

	task automatic send_ctrl_beat(input logic last, input logic [255:0] data);
		ctrl_tdata = data;
		ctrl_tlast = last;
		ctrl_tvalid = 1'b1;
		@(posedge axis_clk);
		#2;
		ctrl_tvalid = 1'b0;
		ctrl_tlast = 1'b0;
	endtask

	task automatic send_pkt_beat(input logic last, input logic [127:0] tuser,
			input logic [255:0] data);
		s_axis_tdata = data;
		s_axis_tuser = tuser;
		s_axis_tlast = last;
		s_axis_tvalid = 1'b1;
		@(posedge axis_clk);
		while (!s_axis_tready)
			@(posedge axis_clk);
		#2;
		s_axis_tvalid = 1'b0;
		s_axis_tlast = 1'b0;
	endtask

	// until the checker has seen every expected PHV
	task automatic drain_phv();
		while (u_checker.outstanding() != 0) begin
			@(posedge axis_clk);
			#2;
		end
	endtask

	task automatic set_expected_container(input int width, input int idx,
			input logic [47:0] value);
		case (width)
			2: exp_phv.cont_2b[idx] = value[15:0];
			4: exp_phv.cont_4b[idx] = value[31:0];
			6: exp_phv.cont_6b[idx] = value;
			default: begin
				file_errors++;
				$display("golden file names a container of width %0d", width);
			end
		endcase
	endtask

	initial begin
		aresetn = 1'b0;
		s_axis_tdata = '0;
		s_axis_tuser = '0;
		s_axis_tvalid = 1'b0;
		s_axis_tlast = 1'b0;
		ctrl_tdata = '0;
		ctrl_tvalid = 1'b0;
		ctrl_tlast = 1'b0;
		exp_phv = '0;
		cur_name = '0;
		load_golden();
		limit = 64 * recs.size();
		repeat (10) @(posedge axis_clk);
		#2;
		aresetn = 1'b1;
		for (int i = 0; i < recs.size(); i++) begin
			rec = recs[i];
			case (rec.tag)
				"T": cur_name = names[rec.a];
				"R": ready_mode = rec.a;
				"C": send_ctrl_beat(rec.a[0], rec.d);
				"P": begin
					if (rec.a[0]) begin
						u_checker.expect_phv(exp_phv);
						exp_phv = '0;
					end
					send_pkt_beat(rec.a[0], rec.u, rec.d);
					if (rec.a[0])
						drain_phv();
				end
				"K": set_expected_container(rec.a, rec.b, rec.u[47:0]);
				"V": begin
					exp_phv.vlan_id = rec.a[11:0];
					exp_phv.tuser = rec.u;
				end
				"E": u_checker.finish_test(cur_name);
				default: ;
			endcase
		end
		// catch late or extra pulses
		repeat (8) @(posedge axis_clk);
		u_checker.report_counts();
		if (file_errors == 0 && u_checker.errors == 0 && u_checker.tests_run > 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
